// File: dest_mux_pkg.sv
/*
 * Destination mux package.
 * Sizes shared by the request sequencer, its queue, the request slice and the data mux.
 */

package dest_mux_pkg;

    // Data path.
    localparam int DATA_BITS     = 64;                    // Width of one data beat.
    localparam int BEAT_BYTES    = DATA_BITS / 8;         // Bytes carried by one beat.
    localparam int BEAT_LOG_BITS = $clog2(BEAT_BYTES);    // Shift from bytes to beats.

    // Request fields.
    localparam int LEN_BITS   = 16;                       // Byte length of a transfer.
    localparam int BLEN_BITS  = LEN_BITS - BEAT_LOG_BITS; // Beat count minus one.
    localparam int PID_BITS   = 6;                        // Process id.
    localparam int VADDR_BITS = 48;                       // Virtual address.

    // Destinations.
    localparam int N_DESTS   = 4;                         // Number of output streams.
    localparam int DEST_BITS = $clog2(N_DESTS);           // Index of one output stream.

    // Outstanding transfers.
    localparam int N_OUTSTANDING = 8;                     // Depth of the sequence queue.
    localparam int QPTR_BITS     = $clog2(N_OUTSTANDING); // Queue pointer width.

    // A sequence entry is {pid, dest, blen}, pid in the top bits.
    localparam int SEQ_BITS     = PID_BITS + DEST_BITS + BLEN_BITS;
    localparam int SEQ_BLEN_LSB = 0;                      // Beat count sits at the bottom.
    localparam int SEQ_DEST_LSB = SEQ_BLEN_LSB + BLEN_BITS; // Destination above the count.
    localparam int SEQ_PID_LSB  = SEQ_DEST_LSB + DEST_BITS; // Pid on top of the entry.

    // A full request word as held in the register slice, {pid, len, dest, vaddr}.
    localparam int REQ_BITS = PID_BITS + LEN_BITS + DEST_BITS + VADDR_BITS;

endpackage

// File: req_seq_queue.sv
/*
 * Sequence queue.
 * Synchronous FIFO holding one short entry per outstanding transfer, oldest first.
 */

`timescale 1ns/1ns

module req_seq_queue (
    input  logic                                aclk,
    input  logic                                arst_n,

    // Write side from the sequencer.
    input  logic                                wr_valid,
    output logic                                wr_ready,
    input  logic [dest_mux_pkg::SEQ_BITS-1:0]   wr_entry,

    // Read side toward the data mux.
    output logic                                rd_valid,
    input  logic                                rd_ready,
    output logic [dest_mux_pkg::SEQ_BITS-1:0]   rd_entry
);

    logic [dest_mux_pkg::SEQ_BITS-1:0]  mem [dest_mux_pkg::N_OUTSTANDING]; // Entry storage.
    logic [dest_mux_pkg::QPTR_BITS-1:0] wr_ptr_q;   // Next free slot.
    logic [dest_mux_pkg::QPTR_BITS-1:0] rd_ptr_q;   // Oldest entry.
    logic [dest_mux_pkg::QPTR_BITS:0]   count_q;    // Occupancy needs one bit more than a pointer.
    logic                               wr_en;
    logic                               rd_en;

    assign wr_ready = (count_q != dest_mux_pkg::N_OUTSTANDING); // Space left in the queue.
    assign rd_valid = (count_q != '0);                          // At least one entry held.
    assign rd_entry = mem[rd_ptr_q];                            // Head is always on the port.

    assign wr_en = wr_valid & wr_ready; // Push on a write handshake.
    assign rd_en = rd_valid & rd_ready; // Pop on a read handshake.

    // A push writes the entry storage.
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= wr_entry; // New entry goes into the free slot.
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // The pointer wraps since the depth is a power of two.
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1; // Push only.
                2'b01:   count_q <= count_q - 1'b1; // Pop only.
                default: count_q <= count_q;        // Both or neither keeps the level.
            endcase
        end
    end

    // The sequencer only raises wr_valid when the queue has room.
    a_no_write_full: assert property (
        @(posedge aclk) disable iff (!arst_n) wr_valid |-> wr_ready
    ) else $error("Sequence queue written while full.");

    // The data mux pops only an entry it has just finished.
    a_no_pop_empty: assert property (
        @(posedge aclk) disable iff (!arst_n) rd_ready |-> rd_valid
    ) else $error("Sequence queue popped while empty.");

endmodule

// File: req_reg.sv
/*
 * Request register slice.
 * Two-entry skid buffer with a registered ready, keeps order and full rate.
 */

`timescale 1ns/1ns

module req_reg (
    input  logic                                    aclk,
    input  logic                                    arst_n,

    input  logic                                    in_valid,
    output logic                                    in_ready,
    input  logic [dest_mux_pkg::PID_BITS-1:0]       in_pid,
    input  logic [dest_mux_pkg::LEN_BITS-1:0]       in_len,
    input  logic [dest_mux_pkg::DEST_BITS-1:0]      in_dest,
    input  logic [dest_mux_pkg::VADDR_BITS-1:0]     in_vaddr,

    output logic                                    out_valid,
    input  logic                                    out_ready,
    output logic [dest_mux_pkg::PID_BITS-1:0]       out_pid,
    output logic [dest_mux_pkg::LEN_BITS-1:0]       out_len,
    output logic [dest_mux_pkg::DEST_BITS-1:0]      out_dest,
    output logic [dest_mux_pkg::VADDR_BITS-1:0]     out_vaddr
);

    logic [dest_mux_pkg::REQ_BITS-1:0] out_data_q;  // Request on the output.
    logic [dest_mux_pkg::REQ_BITS-1:0] skid_data_q; // Request caught during a stall.
    logic                              out_valid_q;
    logic                              skid_valid_q;
    logic                              in_fire;

    assign in_ready = ~skid_valid_q;          // Straight from a flop, no path from out_ready.
    assign in_fire  = in_valid & in_ready;
    assign out_valid = out_valid_q;
    assign {out_pid, out_len, out_dest, out_vaddr} = out_data_q;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (!out_valid_q || out_ready) begin
            out_valid_q  <= skid_valid_q | in_fire; // Skid entry is older, it leaves first.
            skid_valid_q <= 1'b0;
        end else if (in_fire) begin
            skid_valid_q <= 1'b1;                   // Output stalled, park the new request.
        end
    end

    always_ff @(posedge aclk) begin
        if (!out_valid_q || out_ready) begin
            out_data_q <= skid_valid_q ? skid_data_q : {in_pid, in_len, in_dest, in_vaddr};
        end
        if (in_fire) begin
            skid_data_q <= {in_pid, in_len, in_dest, in_vaddr}; // Only kept if out stalls.
        end
    end

endmodule

// File: dest_req_seq.sv
/*
 * Destination request sequencer.
 * Accepts a request only when queue and slice both take it, and writes both copies.
 */

`timescale 1ns/1ns

module dest_req_seq (
    input  logic                                    aclk,
    input  logic                                    arst_n,

    // Incoming requests.
    input  logic                                    s_req_valid,
    output logic                                    s_req_ready,
    input  logic [dest_mux_pkg::PID_BITS-1:0]       s_req_pid,
    input  logic [dest_mux_pkg::LEN_BITS-1:0]       s_req_len,
    input  logic [dest_mux_pkg::DEST_BITS-1:0]      s_req_dest,
    input  logic [dest_mux_pkg::VADDR_BITS-1:0]     s_req_vaddr,

    // Sequence entries toward the queue.
    output logic                                    seq_wr_valid,
    input  logic                                    seq_wr_ready,
    output logic [dest_mux_pkg::SEQ_BITS-1:0]       seq_wr_entry,

    // Requests toward the memory side.
    output logic                                    m_req_valid,
    input  logic                                    m_req_ready,
    output logic [dest_mux_pkg::PID_BITS-1:0]       m_req_pid,
    output logic [dest_mux_pkg::LEN_BITS-1:0]       m_req_len,
    output logic [dest_mux_pkg::DEST_BITS-1:0]      m_req_dest,
    output logic [dest_mux_pkg::VADDR_BITS-1:0]     m_req_vaddr
);

    logic                                   slice_ready; // Slice can take a request.
    logic                                   req_fire;    // Request accepted this cycle.
    logic [dest_mux_pkg::LEN_BITS-1:0]      len_m1;      // Byte length minus one.
    logic [dest_mux_pkg::BLEN_BITS-1:0]     n_tr;        // Beat count minus one.

    assign s_req_ready = seq_wr_ready & slice_ready; // Joint ready keeps both copies together.
    assign req_fire    = s_req_valid & s_req_ready;

    // Dropping the low bits of len - 1 is the shift by BEAT_LOG_BITS.
    assign len_m1 = s_req_len - 1'b1;
    assign n_tr   = len_m1[dest_mux_pkg::LEN_BITS-1:dest_mux_pkg::BEAT_LOG_BITS];

    assign seq_wr_valid = req_fire;
    assign seq_wr_entry = {s_req_pid, s_req_dest, n_tr}; // Same order as the package offsets.

    req_reg u_req_reg (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .in_valid  (req_fire),
        .in_ready  (slice_ready),
        .in_pid    (s_req_pid),
        .in_len    (s_req_len),
        .in_dest   (s_req_dest),
        .in_vaddr  (s_req_vaddr),
        .out_valid (m_req_valid),
        .out_ready (m_req_ready),
        .out_pid   (m_req_pid),
        .out_len   (m_req_len),
        .out_dest  (m_req_dest),
        .out_vaddr (m_req_vaddr)
    );

    // A zero length would wrap the beat count to its maximum.
    a_len_nonzero: assert property (
        @(posedge aclk) disable iff (!arst_n) req_fire |-> (s_req_len != '0)
    ) else $error("Request accepted with zero length.");

endmodule

// File: dest_data_mux.sv
/*
 * Destination data mux.
 * Steers the beats of each queued transfer from one stream to its destination.
 */

`timescale 1ns/1ns

module dest_data_mux (
    input  logic                                    aclk,
    input  logic                                    arst_n,

    // Head of the sequence queue.
    input  logic                                    seq_valid,
    output logic                                    seq_ready,
    input  logic [dest_mux_pkg::SEQ_BITS-1:0]       seq_entry,

    // Shared data input.
    input  logic                                    s_data_valid,
    output logic                                    s_data_ready,
    input  logic [dest_mux_pkg::DATA_BITS-1:0]      s_data,

    // Destination streams, data and tags are shared.
    output logic [dest_mux_pkg::N_DESTS-1:0]        m_data_valid,
    input  logic [dest_mux_pkg::N_DESTS-1:0]        m_data_ready,
    output logic [dest_mux_pkg::DATA_BITS-1:0]      m_data,
    output logic                                    m_data_last,
    output logic [dest_mux_pkg::PID_BITS-1:0]       m_data_pid
);

    logic [dest_mux_pkg::PID_BITS-1:0]  cur_pid;    // Pid of the current transfer.
    logic [dest_mux_pkg::DEST_BITS-1:0] cur_dest;   // Destination of the current transfer.
    logic [dest_mux_pkg::BLEN_BITS-1:0] cur_blen;   // Beat count minus one.
    logic [dest_mux_pkg::BLEN_BITS-1:0] beat_cnt_q; // Beats already sent.
    logic                               is_last;
    logic                               beat_fire;

    // Unpack the head entry.
    assign cur_pid  = seq_entry[dest_mux_pkg::SEQ_PID_LSB +: dest_mux_pkg::PID_BITS];
    assign cur_dest = seq_entry[dest_mux_pkg::SEQ_DEST_LSB +: dest_mux_pkg::DEST_BITS];
    assign cur_blen = seq_entry[dest_mux_pkg::SEQ_BLEN_LSB +: dest_mux_pkg::BLEN_BITS];

    assign is_last = (beat_cnt_q == cur_blen); // Final beat once the count reaches blen.

    // Only the chosen destination sees valid, and only it drives the input ready.
    always_comb begin
        m_data_valid           = '0;
        m_data_valid[cur_dest] = s_data_valid & seq_valid;
        s_data_ready           = seq_valid & m_data_ready[cur_dest];
    end

    assign m_data      = s_data;              // Payload passes through untouched.
    assign m_data_last = seq_valid & is_last;
    assign m_data_pid  = cur_pid;

    assign beat_fire = s_data_valid & s_data_ready;
    assign seq_ready = beat_fire & is_last;   // Pop the entry with its last beat.

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt_q <= '0;
        end else if (beat_fire) begin
            // Clear for the next entry, else move to the next beat.
            beat_cnt_q <= is_last ? '0 : beat_cnt_q + 1'b1;
        end
    end

    // A queued entry must name an existing destination stream.
    a_dest_range: assert property (
        @(posedge aclk) disable iff (!arst_n)
        seq_valid |-> (int'(cur_dest) < dest_mux_pkg::N_DESTS)
    ) else $error("Sequence entry names a missing destination.");

    // The counter never runs past the head entry, even when a new entry arrives.
    a_cnt_bound: assert property (
        @(posedge aclk) disable iff (!arst_n) seq_valid |-> (beat_cnt_q <= cur_blen)
    ) else $error("Beat count ran past the transfer length.");

endmodule

// File: dest_mux_top.sv
/*
 * Destination mux top level.
 * Request sequencer, sequence queue and data mux wired together.
 */

`timescale 1ns/1ns

module dest_mux_top (
    input  logic                                    aclk,
    input  logic                                    arst_n,

    input  logic                                    s_req_valid,
    output logic                                    s_req_ready,
    input  logic [dest_mux_pkg::PID_BITS-1:0]       s_req_pid,
    input  logic [dest_mux_pkg::LEN_BITS-1:0]       s_req_len,
    input  logic [dest_mux_pkg::DEST_BITS-1:0]      s_req_dest,
    input  logic [dest_mux_pkg::VADDR_BITS-1:0]     s_req_vaddr,

    output logic                                    m_req_valid,
    input  logic                                    m_req_ready,
    output logic [dest_mux_pkg::PID_BITS-1:0]       m_req_pid,
    output logic [dest_mux_pkg::LEN_BITS-1:0]       m_req_len,
    output logic [dest_mux_pkg::DEST_BITS-1:0]      m_req_dest,
    output logic [dest_mux_pkg::VADDR_BITS-1:0]     m_req_vaddr,

    input  logic                                    s_data_valid,
    output logic                                    s_data_ready,
    input  logic [dest_mux_pkg::DATA_BITS-1:0]      s_data,

    output logic [dest_mux_pkg::N_DESTS-1:0]        m_data_valid,
    input  logic [dest_mux_pkg::N_DESTS-1:0]        m_data_ready,
    output logic [dest_mux_pkg::DATA_BITS-1:0]      m_data,
    output logic                                    m_data_last,
    output logic [dest_mux_pkg::PID_BITS-1:0]       m_data_pid
);

    logic                               seq_wr_valid;  // Sequencer pushes an entry.
    logic                               seq_wr_ready;  // Queue has room.
    logic [dest_mux_pkg::SEQ_BITS-1:0]  seq_wr_entry;
    logic                               seq_valid;     // Head entry present.
    logic                               seq_ready;     // Mux pops the head.
    logic [dest_mux_pkg::SEQ_BITS-1:0]  seq_entry;

    dest_req_seq u_dest_req_seq (
        .aclk         (aclk),          .arst_n       (arst_n),
        .s_req_valid  (s_req_valid),   .s_req_ready  (s_req_ready),
        .s_req_pid    (s_req_pid),     .s_req_len    (s_req_len),
        .s_req_dest   (s_req_dest),    .s_req_vaddr  (s_req_vaddr),
        .seq_wr_valid (seq_wr_valid),  .seq_wr_ready (seq_wr_ready),
        .seq_wr_entry (seq_wr_entry),
        .m_req_valid  (m_req_valid),   .m_req_ready  (m_req_ready),
        .m_req_pid    (m_req_pid),     .m_req_len    (m_req_len),
        .m_req_dest   (m_req_dest),    .m_req_vaddr  (m_req_vaddr)
    );

    req_seq_queue u_req_seq_queue (
        .aclk     (aclk),         .arst_n   (arst_n),
        .wr_valid (seq_wr_valid), .wr_ready (seq_wr_ready), .wr_entry (seq_wr_entry),
        .rd_valid (seq_valid),    .rd_ready (seq_ready),    .rd_entry (seq_entry)
    );

    dest_data_mux u_dest_data_mux (
        .aclk         (aclk),         .arst_n       (arst_n),
        .seq_valid    (seq_valid),    .seq_ready    (seq_ready),    .seq_entry (seq_entry),
        .s_data_valid (s_data_valid), .s_data_ready (s_data_ready), .s_data    (s_data),
        .m_data_valid (m_data_valid), .m_data_ready (m_data_ready), .m_data    (m_data),
        .m_data_last  (m_data_last),  .m_data_pid   (m_data_pid)
    );

endmodule

// File: tb_dest_mux.sv
/*
 * Testbench for the destination mux.
 * Directed tests against a request and beat model, with an output monitor and a watchdog.
 */

`timescale 1ns/1ns

module tb_dest_mux;

    localparam int CLK_PERIOD     = 8;   // Clock period in ns.
    localparam int N_TESTS        = 6;   // Number of test tasks run below.
    localparam int N_RAND_REQS    = 12;  // Requests in the back-pressure test.
    localparam int MAX_TEST_BEATS = 96;  // Largest beat total of one test.
    localparam int TIMEOUT_NS     = N_TESTS * MAX_TEST_BEATS * 20 * CLK_PERIOD;
    localparam int BEAT_W = dest_mux_pkg::DEST_BITS + dest_mux_pkg::PID_BITS + 1
                          + dest_mux_pkg::DATA_BITS; // Expected beat is {dest, pid, last, data}.

    logic                                   aclk;
    logic                                   arst_n;
    logic                                   s_req_valid;
    logic                                   s_req_ready;
    logic [dest_mux_pkg::PID_BITS-1:0]      s_req_pid;
    logic [dest_mux_pkg::LEN_BITS-1:0]      s_req_len;
    logic [dest_mux_pkg::DEST_BITS-1:0]     s_req_dest;
    logic [dest_mux_pkg::VADDR_BITS-1:0]    s_req_vaddr;
    logic                                   m_req_valid;
    logic                                   m_req_ready;
    logic [dest_mux_pkg::PID_BITS-1:0]      m_req_pid;
    logic [dest_mux_pkg::LEN_BITS-1:0]      m_req_len;
    logic [dest_mux_pkg::DEST_BITS-1:0]     m_req_dest;
    logic [dest_mux_pkg::VADDR_BITS-1:0]    m_req_vaddr;
    logic                                   s_data_valid;
    logic                                   s_data_ready;
    logic [dest_mux_pkg::DATA_BITS-1:0]     s_data;
    logic [dest_mux_pkg::N_DESTS-1:0]       m_data_valid;
    logic [dest_mux_pkg::N_DESTS-1:0]       m_data_ready;
    logic [dest_mux_pkg::DATA_BITS-1:0]     m_data;
    logic                                   m_data_last;
    logic [dest_mux_pkg::PID_BITS-1:0]      m_data_pid;

    integer seed = 32'h1546_87ba;                     // Seed for all $random calls.

    logic [dest_mux_pkg::REQ_BITS-1:0]  exp_req [$];  // Requests still due on m_req.
    logic [BEAT_W-1:0]                  exp_beat [$]; // Beats driven but not yet seen.
    logic [dest_mux_pkg::PID_BITS-1:0]  pend_pid [$]; // Transfers whose data is not sent yet.
    logic [dest_mux_pkg::DEST_BITS-1:0] pend_dest [$];
    int                                 pend_beats [$];

    int                                 fail_count;
    logic [31:0]                        data_tag;     // Makes every driven beat unique.
    logic                               bp_stop;      // Ends the random ready process.
    logic [dest_mux_pkg::REQ_BITS-1:0]  req_exp;
    logic [BEAT_W-1:0]                  beat_exp;
    logic [dest_mux_pkg::N_DESTS-1:0]   dest_onehot;

    dest_mux_top u_dest_mux_top (
        .aclk         (aclk),         .arst_n       (arst_n),
        .s_req_valid  (s_req_valid),  .s_req_ready  (s_req_ready),
        .s_req_pid    (s_req_pid),    .s_req_len    (s_req_len),
        .s_req_dest   (s_req_dest),   .s_req_vaddr  (s_req_vaddr),
        .m_req_valid  (m_req_valid),  .m_req_ready  (m_req_ready),
        .m_req_pid    (m_req_pid),    .m_req_len    (m_req_len),
        .m_req_dest   (m_req_dest),   .m_req_vaddr  (m_req_vaddr),
        .s_data_valid (s_data_valid), .s_data_ready (s_data_ready), .s_data (s_data),
        .m_data_valid (m_data_valid), .m_data_ready (m_data_ready), .m_data (m_data),
        .m_data_last  (m_data_last),  .m_data_pid   (m_data_pid)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired because the tests did not finish in time. The DUT seems hung.");
        $display("Result: FAILED");
        $fatal(1, "Run stopped by the watchdog.");
    end

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_count++;
            $display("[FAIL] %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    // Each handshake is judged at the falling edge, half a cycle before it completes.
    always @(negedge aclk) begin : output_monitor
        if (arst_n) begin
            if (m_req_valid && m_req_ready) begin
                if (exp_req.size() == 0) begin
                    check_value(m_req_valid, 1'b0, "request on m_req with none outstanding");
                end else begin
                    req_exp = exp_req.pop_front(); // Requests leave in the order they came.
                    check_value({m_req_pid, m_req_len, m_req_dest, m_req_vaddr}, req_exp,
                                "request fields on m_req");
                end
            end
            if (s_data_valid && s_data_ready) begin
                check_value(|m_data_valid, 1'b1, "input beat taken with no destination valid");
            end
            if (m_data_valid != '0) begin
                if (exp_beat.size() == 0) begin
                    check_value(m_data_valid, '0, "destination valid with no beat outstanding");
                end else begin
                    beat_exp = exp_beat[0];
                    dest_onehot = '0;
                    dest_onehot[beat_exp[BEAT_W-1 -: dest_mux_pkg::DEST_BITS]] = 1'b1;
                    check_value(m_data_valid, dest_onehot, "destination select");
                    if ((m_data_valid & m_data_ready) != '0) begin
                        check_value(m_data, beat_exp[dest_mux_pkg::DATA_BITS-1:0], "beat data");
                        check_value(m_data_last, beat_exp[dest_mux_pkg::DATA_BITS], "last flag");
                        check_value(m_data_pid,
                                    beat_exp[dest_mux_pkg::DATA_BITS+1 +: dest_mux_pkg::PID_BITS],
                                    "beat pid tag");
                        void'(exp_beat.pop_front());
                    end
                end
            end
        end
    end

    // Every task below starts and ends 1 ns after a rising edge.
    task automatic send_req(input logic [dest_mux_pkg::PID_BITS-1:0] pid,
                            input logic [dest_mux_pkg::LEN_BITS-1:0] len,
                            input logic [dest_mux_pkg::DEST_BITS-1:0] dest,
                            input logic [dest_mux_pkg::VADDR_BITS-1:0] vaddr);
        exp_req.push_back({pid, len, dest, vaddr});
        pend_pid.push_back(pid);
        pend_dest.push_back(dest);
        pend_beats.push_back((int'(len) + 7) / 8);          // Beats are len rounded up to 8 bytes.
        s_req_valid = 1'b1;
        s_req_pid   = pid;
        s_req_len   = len;
        s_req_dest  = dest;
        s_req_vaddr = vaddr;
        @(negedge aclk);
        while (!s_req_ready) @(negedge aclk);               // Hold until the sequencer takes it.
        @(posedge aclk);
        #1;
        s_req_valid = 1'b0;
    endtask

    task automatic send_data(input int n_xfers);
        logic [dest_mux_pkg::PID_BITS-1:0]  pid;
        logic [dest_mux_pkg::DEST_BITS-1:0] dest;
        logic [dest_mux_pkg::DATA_BITS-1:0] word;
        int                                 beats;
        for (int x = 0; x < n_xfers; x++) begin
            while (pend_beats.size() == 0) begin
                @(posedge aclk);
                #1;
            end
            pid   = pend_pid.pop_front();                   // Data follows request order.
            dest  = pend_dest.pop_front();
            beats = pend_beats.pop_front();
            for (int b = 0; b < beats; b++) begin
                word = {data_tag, ~data_tag};
                data_tag++;
                exp_beat.push_back({dest, pid, (b == beats - 1), word});
                s_data_valid = 1'b1;
                s_data       = word;
                @(negedge aclk);
                while (!s_data_ready) @(negedge aclk);
                @(posedge aclk);
                #1;
            end
        end
        s_data_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_req.size() != 0 || exp_beat.size() != 0 || pend_beats.size() != 0) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
    endtask

    task automatic reset_state();
        @(negedge aclk);
        check_value(m_req_valid, 1'b0, "m_req_valid after reset");
        check_value(m_data_valid, '0, "m_data_valid after reset");
        check_value(s_data_ready, 1'b0, "s_data_ready after reset");
        check_value(s_req_ready, 1'b1, "s_req_ready after reset");
        @(posedge aclk);
        #1;
    endtask

    task automatic single_request();
        send_req(6'h2a, 16'd24, 2'd1, 48'h1234_5678_9abc);
        @(negedge aclk);
        check_value(m_req_valid, 1'b1, "m_req_valid on the edge after the accept");
        @(posedge aclk);
        #1;
        send_data(1);
        wait_idle();
    endtask

    task automatic route_lengths();
        logic [3:0][15:0] lens;
        lens = {16'd64, 16'd9, 16'd8, 16'd1};               // Element 0 holds the 1 byte case.
        for (int i = 0; i < 4; i++) begin
            send_req(6'(i + 8), lens[i], 2'(3 - i), {16'hbeef, 32'(i * 64)});
            send_data(1);
            wait_idle();
        end
    endtask

    task automatic queued_in_order();
        // All four entries sit in the queue before the first beat is driven.
        send_req(6'h11, 16'd40, 2'd3, 48'h0000_1000_0000);
        send_req(6'h12, 16'd16, 2'd1, 48'h0000_2000_0040);
        send_req(6'h13, 16'd3,  2'd0, 48'h0000_3000_0080);
        send_req(6'h14, 16'd32, 2'd2, 48'h0000_4000_00c0);
        send_data(4);
        wait_idle();
    endtask

    task automatic random_backpressure();
        logic [dest_mux_pkg::LEN_BITS-1:0]   len_tab [N_RAND_REQS];
        logic [dest_mux_pkg::DEST_BITS-1:0]  dest_tab [N_RAND_REQS];
        logic [dest_mux_pkg::VADDR_BITS-1:0] vaddr_tab [N_RAND_REQS];
        for (int i = 0; i < N_RAND_REQS; i++) begin
            len_tab[i]   = 16'(($random(seed) & 63) + 1); // Lengths of 1 to 64 bytes.
            dest_tab[i]  = 2'($random(seed));
            vaddr_tab[i] = {16'($random(seed)), 32'($random(seed))};
        end
        bp_stop = 1'b0;
        fork
            begin
                fork
                    begin
                        for (int i = 0; i < N_RAND_REQS; i++) begin
                            send_req(6'(i + 32), len_tab[i], dest_tab[i], vaddr_tab[i]);
                        end
                    end
                    send_data(N_RAND_REQS);
                join
                bp_stop = 1'b1;
            end
            begin
                while (!bp_stop) begin
                    @(posedge aclk);
                    #1;
                    m_req_ready  = 1'($random(seed));   // Stalls only the request path.
                    m_data_ready = 4'($random(seed));
                end
            end
        join
        m_req_ready  = 1'b1;
        m_data_ready = '1;
        wait_idle();
    endtask

    task automatic queue_full_stall();
        for (int i = 0; i < dest_mux_pkg::N_OUTSTANDING; i++) begin
            send_req(6'(i + 48), 16'd16, 2'(i), 48'(i * 256));
        end
        @(negedge aclk);
        check_value(s_req_ready, 1'b0, "s_req_ready with a full queue");
        @(posedge aclk);
        #1;
        send_data(1);
        @(negedge aclk);
        check_value(s_req_ready, 1'b1, "s_req_ready after one transfer drained");
        @(posedge aclk);
        #1;
        send_data(dest_mux_pkg::N_OUTSTANDING - 1);
        wait_idle();
    endtask

    initial begin : main
        arst_n       = 1'b0;
        s_req_valid  = 1'b0;
        s_req_pid    = '0;
        s_req_len    = '0;
        s_req_dest   = '0;
        s_req_vaddr  = '0;
        m_req_ready  = 1'b1;
        s_data_valid = 1'b0;
        s_data       = '0;
        m_data_ready = '1;
        fail_count   = 0;
        data_tag     = 32'h0000_0100;
        bp_stop      = 1'b0;
        repeat (2) @(posedge aclk);
        #1;
        arst_n = 1'b1;
        reset_state();
        single_request();
        route_lengths();
        queued_in_order();
        random_backpressure();
        queue_full_stall();
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: dest_mux.f
dest_mux_pkg.sv
req_seq_queue.sv
req_reg.sv
dest_req_seq.sv
dest_data_mux.sv
dest_mux_top.sv
tb_dest_mux.sv

// File: Bender.yml
package:
  name: dest_mux

sources:
  # Package first, then the leaf modules, then the top level.
  - dest_mux_pkg.sv
  - req_seq_queue.sv
  - req_reg.sv
  - dest_req_seq.sv
  - dest_data_mux.sv
  - dest_mux_top.sv

  # Testbench with top module tb_dest_mux.
  - target: test
    files:
      - tb_dest_mux.sv
